// File: cached_afu.f
common/afu_pkg.sv
hw/job_ctrl.sv
hw/error_ctrl.sv
hw/mmio_regs.sv
hw/wed_fetch.sv
command/cmd_arbiter.sv
hw/compute_unit.sv
hw/cached_afu.sv
tb/host_mem.sv
tb/cached_afu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
EXE=sim_cached_afu

verilator --binary --timing -Wno-fatal --top-module cached_afu_tb \
  -f cached_afu.f --Mdir "$BUILD_DIR" -o "$EXE"
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

exit 0

// File: tb/cached_afu_tb.sv
`timescale 1ns/100ps

module cached_afu_tb;

  import afu_pkg::*;

  localparam int          CLK_PERIOD      = 40;
  localparam int          ADDR_W          = 32;
  localparam int          MAX_COUNT       = 16;
  localparam int          CYCLES_PER_WORD = 200;
  localparam int          MMIO_LIMIT      = 50;
  localparam logic [31:0] SEED            = 32'hca4a_c0ea;
  // Upper bound on words over all jobs of the run
  localparam int          TOTAL_WORDS     = 256;
  localparam int          WATCHDOG_CYCLES = TOTAL_WORDS * 2000 + 10000;

  logic                   clock = 1'b0;
  logic                   rst_n;
  job_in_t                job_in;
  job_out_t               job_out;
  mmio_in_t               mmio_in;
  mmio_out_t              mmio_out;
  mem_cmd_t               mem_cmd;
  mem_rsp_t               mem_rsp;
  logic                   bad_en;
  logic [HOST_ADDR_W-1:0] bad_addr;

  int    tests_run;
  int    tests_failed;
  int    checks;
  int    errors;
  int    test_errors;
  int    job_num;
  string cur_test;

  // Current job layout and data
  logic [31:0] cur_base;
  logic [31:0] cur_src;
  logic [31:0] cur_dst;
  int          cur_count;
  logic [47:0] cur_addend;
  logic [63:0] src_words [MAX_COUNT];

  cached_afu #(
    .ADDR_W(ADDR_W)
  ) cached_afu_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .job_in  (job_in),
    .job_out (job_out),
    .mmio_in (mmio_in),
    .mmio_out(mmio_out),
    .mem_cmd (mem_cmd),
    .mem_rsp (mem_rsp)
  );

  host_mem host_mem_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .mem_cmd (mem_cmd),
    .bad_en  (bad_en),
    .bad_addr(bad_addr),
    .mem_rsp (mem_rsp)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Destination word is source plus addend modulo 2^64
  function automatic logic [63:0] expected_word(input logic [63:0] src, input logic [47:0] addend);
    logic [64:0] full;
    full = {1'b0, src} + {17'b0, addend};
    return full[63:0];
  endfunction

  function automatic job_out_t make_status(input logic running, input logic done,
                                           input logic failed);
    job_out_t s;
    s.running = running;
    s.done    = done;
    s.failed  = failed;
    return s;
  endfunction

  function automatic logic [ERR_W-1:0] err_mask(input err_bit_e b);
    logic [ERR_W-1:0] m;
    m    = '0;
    m[b] = 1'b1;
    return m;
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      note_error();
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input job_out_t got, input job_out_t exp);
    checks++;
    if (got !== exp) begin
      note_error();
      $display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_errors(input string name, input logic [ERR_W-1:0] got,
                              input logic [ERR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      note_error();
      $display("FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic begin_test(input string name);
    tests_run++;
    test_errors = 0;
    cur_test    = name;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // MMIO and job drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_mmio_ack(input logic level);
    int n;
    n = 0;
    @(negedge clock);
    while ((mmio_out.ack !== level) && (n < MMIO_LIMIT)) begin
      @(negedge clock);
      n++;
    end
    if (mmio_out.ack !== level) begin
      note_error();
      $display("MMIO ack did not go to %0d within %0d cycles at t=%0t", level, MMIO_LIMIT, $time);
    end
  endtask

  task automatic mmio_access(input logic write, input mmio_reg_e addr,
                             input logic [63:0] wdata, output logic [63:0] rdata);
    @(posedge clock);
    mmio_in <= '{req: 1'b1, write: write, addr: addr, wdata: wdata};
    wait_mmio_ack(1'b1);
    rdata = mmio_out.rdata;
    @(posedge clock);
    mmio_in.req <= 1'b0;
    wait_mmio_ack(1'b0);
  endtask

  task automatic mmio_write(input mmio_reg_e addr, input logic [63:0] wdata);
    logic [63:0] unused;
    mmio_access(1'b1, addr, wdata, unused);
  endtask

  task automatic expect_errors(input logic [ERR_W-1:0] exp);
    logic [63:0] rdata;
    mmio_access(1'b0, REG_ERRORS, 64'h0, rdata);
    check_errors("REG_ERRORS", rdata[ERR_W-1:0], exp);
  endtask

  // Status register holds running in bit 0, done in bit 1 and failed in bit 2
  task automatic expect_status_reg(input job_out_t exp);
    logic [63:0] rdata;
    mmio_access(1'b0, REG_STATUS, 64'h0, rdata);
    check_status("REG_STATUS", make_status(rdata[0], rdata[1], rdata[2]), exp);
  endtask

  // Descriptor and source words for the next job in a region of its own
  task automatic setup_job(input int count);
    int i;
    job_num++;
    cur_base   = 32'h0010_0000 + 32'(job_num) * 32'h0000_1000;
    cur_src    = cur_base + 32'h0000_0100;
    cur_dst    = cur_base + 32'h0000_0800;
    cur_count  = count;
    cur_addend = 48'({$urandom, $urandom});
    for (i = 0; i < count; i++) begin
      // First word near the top so the sum wraps
      if (i == 0) begin
        src_words[i] = 64'hffff_ffff_ffff_fff0 + 64'($urandom_range(15, 0));
      end else begin
        src_words[i] = {$urandom, $urandom};
      end
      host_mem_i.write_word(cur_src + 32'(8 * i), src_words[i]);
    end
    host_mem_i.write_word(cur_base, {cur_dst, cur_src});
    host_mem_i.write_word(cur_base + 32'h8, {cur_addend, 16'(count)});
  endtask

  task automatic start_job();
    @(posedge clock);
    job_in <= '{start: 1'b1, reset: 1'b0, wed_addr: cur_base};
    @(posedge clock);
    job_in.start <= 1'b0;
  endtask

  task automatic wait_done(output bit seen);
    int limit;
    int n;
    limit = (cur_count + 2) * CYCLES_PER_WORD;
    n     = 0;
    seen  = 1'b0;
    while (!seen && (n < limit)) begin
      @(negedge clock);
      seen = job_out.done;
      n++;
    end
    if (!seen) begin
      note_error();
      $display("Job %0d did not raise done within %0d cycles", job_num, limit);
    end
  endtask

  task automatic wait_mem_write();
    int n;
    n = 0;
    @(negedge clock);
    while (!(mem_cmd.req && (mem_cmd.op == MEM_WRITE)) && (n < 4 * CYCLES_PER_WORD)) begin
      @(negedge clock);
      n++;
    end
    if (!(mem_cmd.req && (mem_cmd.op == MEM_WRITE))) begin
      note_error();
      $display("No memory write was issued by job %0d at t=%0t", job_num, $time);
    end
  endtask

  task automatic verify_job();
    logic [63:0] rdata;
    int          i;
    check_status("job_out", job_out, make_status(1'b0, 1'b1, 1'b0));
    expect_status_reg(make_status(1'b0, 1'b1, 1'b0));
    mmio_access(1'b0, REG_PROGRESS, 64'h0, rdata);
    check_word("REG_PROGRESS", rdata, 64'(cur_count));
    for (i = 0; i < cur_count; i++) begin
      check_word($sformatf("dst[%0d]", i), host_mem_i.read_word(cur_dst + 32'(8 * i)),
                 expected_word(src_words[i], cur_addend));
      check_word($sformatf("src[%0d]", i), host_mem_i.read_word(cur_src + 32'(8 * i)),
                 src_words[i]);
    end
  endtask

  task automatic run_good_job(input int count);
    bit seen;
    setup_job(count);
    start_job();
    wait_done(seen);
    if (seen) begin
      verify_job();
    end
  endtask

  // Job ends failed with only the given error bit set
  task automatic expect_failed_job(input err_bit_e b);
    bit seen;
    wait_done(seen);
    if (seen) begin
      check_status("job_out", job_out, make_status(1'b0, 1'b1, 1'b1));
      expect_status_reg(make_status(1'b0, 1'b1, 1'b1));
    end
    expect_errors(err_mask(b));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    void'($urandom(SEED));
    rst_n        = 1'b0;
    job_in       = '0;
    mmio_in      = '0;
    bad_en       = 1'b0;
    bad_addr     = '0;
    tests_run    = 0;
    tests_failed = 0;
    checks       = 0;
    errors       = 0;
    job_num      = 0;
    repeat (2) @(posedge clock);
    rst_n <= 1'b1;

    begin_test("reset");
    @(negedge clock);
    check_status("job_out", job_out, make_status(1'b0, 1'b0, 1'b0));
    check_word("mmio_out.ack", 64'(mmio_out.ack), 64'h0);
    check_word("mem_cmd.req", 64'(mem_cmd.req), 64'h0);
    expect_errors('0);
    expect_status_reg(make_status(1'b0, 1'b0, 1'b0));
    end_test();

    begin_test("job_result");
    run_good_job(int'($urandom_range(MAX_COUNT, 1)));
    end_test();

    begin_test("mmio_addr_error");
    setup_job(MAX_COUNT);
    start_job();
    mmio_write(REG_STATUS, 64'h0);
    expect_failed_job(ERR_MMIO_ADDR);
    mmio_write(REG_ERRORS, 64'h0);
    expect_errors('0);
    mmio_write(REG_CONTROL, 64'h1);
    end_test();

    begin_test("job_start_error");
    setup_job(MAX_COUNT);
    start_job();
    start_job();
    expect_failed_job(ERR_JOB_START);
    mmio_write(REG_CONTROL, 64'h1);
    expect_errors('0);
    end_test();

    begin_test("bad_response");
    setup_job(8);
    @(posedge clock);
    bad_addr <= cur_src + 32'd24;
    bad_en   <= 1'b1;
    start_job();
    expect_failed_job(ERR_MEM_RSP);
    @(posedge clock);
    bad_en <= 1'b0;
    mmio_write(REG_CONTROL, 64'h1);
    end_test();

    begin_test("zero_count");
    setup_job(0);
    start_job();
    expect_failed_job(ERR_WED_COUNT);
    mmio_write(REG_ERRORS, 64'h0);
    expect_errors('0);
    end_test();

    begin_test("soft_reset");
    setup_job(MAX_COUNT);
    start_job();
    wait_mem_write();
    mmio_write(REG_CONTROL, 64'h1);
    @(negedge clock);
    check_status("job_out", job_out, make_status(1'b0, 1'b0, 1'b0));
    run_good_job(int'($urandom_range(MAX_COUNT, 1)));
    end_test();

    begin_test("back_pressure");
    for (i = 0; i < 10; i++) begin
      run_good_job(int'($urandom_range(MAX_COUNT, 1)));
    end
    end_test();

    $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: tb/host_mem.sv
`timescale 1ns/100ps

module host_mem (
  input  logic                         clock,
  input  logic                         rst_n,
  input  afu_pkg::mem_cmd_t            mem_cmd,
  input  logic                         bad_en,
  input  logic [afu_pkg::HOST_ADDR_W-1:0] bad_addr,
  output afu_pkg::mem_rsp_t            mem_rsp
);

  import afu_pkg::*;

  // Sparse host memory, one 64-bit word per byte address
  logic [DATA_W-1:0] mem [logic [HOST_ADDR_W-1:0]];

  function automatic logic [DATA_W-1:0] read_word(input logic [HOST_ADDR_W-1:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    // Untouched locations return a pattern built from the address
    return {~addr, addr};
  endfunction

  task automatic write_word(input logic [HOST_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    mem[addr] = data;
  endtask

  // One four-phase exchange, dropped if req falls during the delay
  task automatic serve_request();
    mem_cmd_t cmd_q;
    int       delay;
    bit       dropped;
    cmd_q   = mem_cmd;
    delay   = int'($urandom_range(5, 0));
    dropped = 1'b0;
    repeat (delay) begin
      @(posedge clock);
      if (!mem_cmd.req) begin
        dropped = 1'b1;
      end
    end
    if (!dropped) begin
      mem_rsp.ack <= 1'b1;
      mem_rsp.ok  <= !(bad_en && (cmd_q.addr == bad_addr));
      if (cmd_q.op == MEM_WRITE) begin
        mem_rsp.rdata <= '0;
        if (!(bad_en && (cmd_q.addr == bad_addr))) begin
          mem[cmd_q.addr] = cmd_q.wdata;
        end
      end else begin
        mem_rsp.rdata <= read_word(cmd_q.addr);
      end
      @(posedge clock);
      while (mem_cmd.req) begin
        @(posedge clock);
      end
      mem_rsp <= '0;
    end
  endtask

  initial begin
    mem_rsp = '0;
    forever begin
      @(posedge clock);
      if (rst_n && mem_cmd.req && !mem_rsp.ack) begin
        serve_request();
      end
    end
  end

endmodule

// File: hw/cached_afu.sv
`timescale 1ns/100ps

module cached_afu #(
  parameter int ADDR_W = 32
) (
  input  logic               clock,
  input  logic               rst_n,
  input  afu_pkg::job_in_t   job_in,
  output afu_pkg::job_out_t  job_out,
  input  afu_pkg::mmio_in_t  mmio_in,
  output afu_pkg::mmio_out_t mmio_out,
  output afu_pkg::mem_cmd_t  mem_cmd,
  input  afu_pkg::mem_rsp_t  mem_rsp
);

  import afu_pkg::*;

  logic               afu_rst_n;
  logic               soft_reset;
  logic               clear_ack;
  logic               start_fetch;
  logic               finish;
  logic               start_err;
  logic               addr_err;
  logic               rsp_err;
  logic               count_err;
  logic [ERR_W-1:0]   err_events;
  logic [ERR_W-1:0]   report_errors;
  logic [COUNT_W-1:0] progress;
  logic               wed_valid;
  wed_t               wed;
  mem_cmd_t           wed_cmd;
  mem_cmd_t           cu_cmd;
  mem_rsp_t           wed_rsp;
  mem_rsp_t           cu_rsp;

  assign err_events[ERR_MMIO_ADDR] = addr_err;
  assign err_events[ERR_MEM_RSP]   = rsp_err;
  assign err_events[ERR_JOB_START] = start_err;
  assign err_events[ERR_WED_COUNT] = count_err;

////////////////////////////////////////////////////////////////////////////
// Job and errors
////////////////////////////////////////////////////////////////////////////

  job_ctrl job_ctrl_instant (
    .clock        (clock),
    .rst_n        (rst_n),
    .job_in       (job_in),
    .finish       (finish),
    .report_errors(report_errors),
    .soft_reset   (soft_reset),
    .job_out      (job_out),
    .afu_rst_n    (afu_rst_n),
    .start_fetch  (start_fetch),
    .start_err    (start_err)
  );

  error_ctrl error_ctrl_instant (
    .clock        (clock),
    .rst_n        (afu_rst_n),
    .enabled      (job_out.running),
    .events       (err_events),
    .clear_ack    (clear_ack),
    .report_errors(report_errors)
  );

////////////////////////////////////////////////////////////////////////////
// MMIO
////////////////////////////////////////////////////////////////////////////

  mmio_regs mmio_regs_instant (
    .clock        (clock),
    .rst_n        (rst_n),
    .mmio_in      (mmio_in),
    .job_out      (job_out),
    .progress     (progress),
    .report_errors(report_errors),
    .mmio_out     (mmio_out),
    .clear_ack    (clear_ack),
    .soft_reset   (soft_reset),
    .addr_err     (addr_err)
  );

////////////////////////////////////////////////////////////////////////////
// Descriptor, memory port and compute
////////////////////////////////////////////////////////////////////////////

  wed_fetch #(
    .ADDR_W(ADDR_W)
  ) wed_fetch_instant (
    .clock    (clock),
    .rst_n    (afu_rst_n),
    .start    (start_fetch),
    .wed_addr (job_in.wed_addr[ADDR_W-1:0]),
    .rsp      (wed_rsp),
    .cmd      (wed_cmd),
    .wed      (wed),
    .wed_valid(wed_valid),
    .count_err(count_err)
  );

  cmd_arbiter #(
    .ADDR_W(ADDR_W)
  ) cmd_arbiter_instant (
    .clock  (clock),
    .rst_n  (afu_rst_n),
    .wed_cmd(wed_cmd),
    .cu_cmd (cu_cmd),
    .mem_rsp(mem_rsp),
    .wed_rsp(wed_rsp),
    .cu_rsp (cu_rsp),
    .mem_cmd(mem_cmd),
    .rsp_err(rsp_err)
  );

  compute_unit #(
    .ADDR_W(ADDR_W)
  ) compute_unit_instant (
    .clock    (clock),
    .rst_n    (afu_rst_n),
    .wed      (wed),
    .wed_valid(wed_valid),
    .rsp      (cu_rsp),
    .cmd      (cu_cmd),
    .progress (progress),
    .finish   (finish)
  );

endmodule

// File: hw/compute_unit.sv
`timescale 1ns/100ps

module compute_unit #(
  parameter int ADDR_W = 32
) (
  input  logic                        clock,
  input  logic                        rst_n,
  input  afu_pkg::wed_t               wed,
  input  logic                        wed_valid,
  input  afu_pkg::mem_rsp_t           rsp,
  output afu_pkg::mem_cmd_t           cmd,
  output logic [afu_pkg::COUNT_W-1:0] progress,
  output logic                        finish
);

  import afu_pkg::*;

  typedef enum logic [2:0] {
    C_IDLE,
    C_RD_REQ,
    C_RD_DROP,
    C_WR_REQ,
    C_WR_DROP
  } cu_state_e;

  cu_state_e          state;
  logic [COUNT_W-1:0] idx;
  logic [DATA_W-1:0]  sum_q;
  logic [ADDR_W-1:0]  offset;
  logic [ADDR_W-1:0]  src_addr;
  logic [ADDR_W-1:0]  dst_addr;
  logic               last_word;

  // Word index to byte offset
  assign offset    = ADDR_W'({idx, 3'b000});
  assign src_addr  = wed.src_addr[ADDR_W-1:0] + offset;
  assign dst_addr  = wed.dst_addr[ADDR_W-1:0] + offset;
  assign last_word = (idx == (wed.count - COUNT_W'(1)));

  always_comb begin
    cmd = '0;
    case (state)
      C_RD_REQ: begin
        cmd.req  = 1'b1;
        cmd.op   = MEM_READ;
        cmd.addr = HOST_ADDR_W'(src_addr);
      end
      C_WR_REQ: begin
        cmd.req   = 1'b1;
        cmd.op    = MEM_WRITE;
        cmd.addr  = HOST_ADDR_W'(dst_addr);
        cmd.wdata = sum_q;
      end
      default: cmd.req = 1'b0;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state    <= C_IDLE;
      idx      <= '0;
      progress <= '0;
      finish   <= 1'b0;
    end else begin
      finish <= 1'b0;
      case (state)
        C_IDLE: begin
          if (wed_valid) begin
            idx      <= '0;
            progress <= '0;
            state    <= C_RD_REQ;
          end
        end
        C_RD_REQ:  if (rsp.ack) state <= C_RD_DROP;
        C_RD_DROP: if (!rsp.ack) state <= C_WR_REQ;
        C_WR_REQ:  if (rsp.ack) state <= C_WR_DROP;
        C_WR_DROP: begin
          // Word counts as done once the write handshake closes
          if (!rsp.ack) begin
            progress <= progress + COUNT_W'(1);
            if (last_word) begin
              finish <= 1'b1;
              state  <= C_IDLE;
            end else begin
              idx   <= idx + COUNT_W'(1);
              state <= C_RD_REQ;
            end
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  // Sum wraps modulo 2^64
  always_ff @(posedge clock) begin
    if ((state == C_RD_REQ) && rsp.ack) begin
      sum_q <= rsp.rdata + wed.addend;
    end
  end

endmodule

// File: command/cmd_arbiter.sv
`timescale 1ns/100ps

module cmd_arbiter #(
  parameter int ADDR_W = 32
) (
  input  logic              clock,
  input  logic              rst_n,
  input  afu_pkg::mem_cmd_t wed_cmd,
  input  afu_pkg::mem_cmd_t cu_cmd,
  input  afu_pkg::mem_rsp_t mem_rsp,
  output afu_pkg::mem_rsp_t wed_rsp,
  output afu_pkg::mem_rsp_t cu_rsp,
  output afu_pkg::mem_cmd_t mem_cmd,
  output logic              rsp_err
);

  import afu_pkg::*;

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_WED,
    GNT_CU
  } grant_e;

  grant_e   grant;
  mem_cmd_t sel_cmd;
  logic     ack_q;

  always_comb begin
    case (grant)
      GNT_WED: sel_cmd = wed_cmd;
      GNT_CU:  sel_cmd = cu_cmd;
      default: sel_cmd = '0;
    endcase
  end

  // Upper address bits beyond ADDR_W never reach the host
  always_comb begin
    mem_cmd      = sel_cmd;
    mem_cmd.addr = HOST_ADDR_W'(sel_cmd.addr[ADDR_W-1:0]);
  end

  // Data and status fan out, only ack is steered
  always_comb begin
    wed_rsp     = mem_rsp;
    wed_rsp.ack = mem_rsp.ack && (grant == GNT_WED);
    cu_rsp      = mem_rsp;
    cu_rsp.ack  = mem_rsp.ack && (grant == GNT_CU);
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      grant   <= GNT_NONE;
      ack_q   <= 1'b0;
      rsp_err <= 1'b0;
    end else begin
      ack_q   <= mem_rsp.ack;
      // Bad status checked once, on the rising ack
      rsp_err <= mem_rsp.ack && !ack_q && !mem_rsp.ok;
      case (grant)
        GNT_NONE: begin
          // Host ack must be low before a new exchange
          if (!mem_rsp.ack) begin
            if (wed_cmd.req) begin
              grant <= GNT_WED;
            end else if (cu_cmd.req) begin
              grant <= GNT_CU;
            end
          end
        end
        default: begin
          // Held until req and ack are both down
          if (!sel_cmd.req && !mem_rsp.ack) begin
            grant <= GNT_NONE;
          end
        end
      endcase
    end
  end

endmodule

// File: hw/wed_fetch.sv
`timescale 1ns/100ps

module wed_fetch #(
  parameter int ADDR_W = 32
) (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              start,
  input  logic [ADDR_W-1:0] wed_addr,
  input  afu_pkg::mem_rsp_t rsp,
  output afu_pkg::mem_cmd_t cmd,
  output afu_pkg::wed_t     wed,
  output logic              wed_valid,
  output logic              count_err
);

  import afu_pkg::*;

  typedef enum logic [1:0] {
    F_IDLE,
    F_REQ,
    F_DROP
  } fetch_state_e;

  fetch_state_e      state;
  logic              word_sel;
  logic [ADDR_W-1:0] base_q;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] word0_q;
  logic [DATA_W-1:0] word1_q;

  // Second word sits 8 bytes above the first
  assign rd_addr = base_q + ADDR_W'({word_sel, 3'b000});

  always_comb begin
    cmd      = '0;
    cmd.req  = (state == F_REQ);
    cmd.op   = MEM_READ;
    cmd.addr = HOST_ADDR_W'(rd_addr);
  end

  // Word 0 holds both addresses, word 1 count and addend
  assign wed.src_addr = HOST_ADDR_W'(word0_q[ADDR_W-1:0]);
  assign wed.dst_addr = HOST_ADDR_W'(word0_q[DATA_W/2 +: ADDR_W]);
  assign wed.count    = word1_q[COUNT_W-1:0];
  assign wed.addend   = DATA_W'(word1_q[DATA_W-1:COUNT_W]);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state     <= F_IDLE;
      word_sel  <= 1'b0;
      wed_valid <= 1'b0;
      count_err <= 1'b0;
    end else begin
      wed_valid <= 1'b0;
      count_err <= 1'b0;
      case (state)
        F_IDLE: begin
          if (start) begin
            word_sel <= 1'b0;
            state    <= F_REQ;
          end
        end
        F_REQ: begin
          if (rsp.ack) begin
            state <= F_DROP;
          end
        end
        F_DROP: begin
          if (!rsp.ack) begin
            if (!word_sel) begin
              word_sel <= 1'b1;
              state    <= F_REQ;
            end else begin
              state     <= F_IDLE;
              count_err <= (wed.count == '0);
              wed_valid <= (wed.count != '0);
            end
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == F_IDLE) && start) begin
      base_q <= wed_addr;
    end
    if ((state == F_REQ) && rsp.ack) begin
      if (word_sel) begin
        word1_q <= rsp.rdata;
      end else begin
        word0_q <= rsp.rdata;
      end
    end
  end

endmodule

// File: hw/mmio_regs.sv
`timescale 1ns/100ps

module mmio_regs (
  input  logic                        clock,
  input  logic                        rst_n,
  input  afu_pkg::mmio_in_t           mmio_in,
  input  afu_pkg::job_out_t           job_out,
  input  logic [afu_pkg::COUNT_W-1:0] progress,
  input  logic [afu_pkg::ERR_W-1:0]   report_errors,
  output afu_pkg::mmio_out_t          mmio_out,
  output logic                        clear_ack,
  output logic                        soft_reset,
  output logic                        addr_err
);

  import afu_pkg::*;

  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rd_mux;
  logic              access;
  logic              wr_access;

  // First cycle of a request, before ack goes up
  assign access    = mmio_in.req && !ack_q;
  assign wr_access = access && mmio_in.write;

  always_comb begin
    case (mmio_in.addr)
      REG_STATUS:
        rd_mux = {{(DATA_W-3){1'b0}}, job_out.failed, job_out.done, job_out.running};
      REG_PROGRESS:
        rd_mux = {{(DATA_W-COUNT_W){1'b0}}, progress};
      REG_ERRORS:
        rd_mux = {{(DATA_W-ERR_W){1'b0}}, report_errors};
      default:
        rd_mux = '0;
    endcase
  end

  // Ack follows req by one cycle in both directions
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ack_q      <= 1'b0;
      clear_ack  <= 1'b0;
      soft_reset <= 1'b0;
      addr_err   <= 1'b0;
    end else begin
      ack_q      <= mmio_in.req;
      clear_ack  <= wr_access && (mmio_in.addr == REG_ERRORS);
      soft_reset <= wr_access && (mmio_in.addr == REG_CONTROL) && mmio_in.wdata[0];
      // Status and progress are read-only
      addr_err   <= wr_access &&
                    ((mmio_in.addr == REG_STATUS) || (mmio_in.addr == REG_PROGRESS));
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      rdata_q <= rd_mux;
    end
  end

  assign mmio_out.ack   = ack_q;
  assign mmio_out.rdata = rdata_q;

endmodule

// File: hw/error_ctrl.sv
`timescale 1ns/100ps

module error_ctrl (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      enabled,
  input  logic [afu_pkg::ERR_W-1:0] events,
  input  logic                      clear_ack,
  output logic [afu_pkg::ERR_W-1:0] report_errors
);

  import afu_pkg::*;

  logic [ERR_W-1:0] taken;

  // Events only count during a job, except a stray start
  always_comb begin
    taken                = enabled ? events : '0;
    taken[ERR_JOB_START] = events[ERR_JOB_START];
  end

  // Sticky bits, a new event beats a clear in the same cycle
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      report_errors <= '0;
    end else if (clear_ack) begin
      report_errors <= taken;
    end else begin
      report_errors <= report_errors | taken;
    end
  end

endmodule

// File: hw/job_ctrl.sv
`timescale 1ns/100ps

module job_ctrl (
  input  logic                      clock,
  input  logic                      rst_n,
  input  afu_pkg::job_in_t          job_in,
  input  logic                      finish,
  input  logic [afu_pkg::ERR_W-1:0] report_errors,
  input  logic                      soft_reset,
  output afu_pkg::job_out_t         job_out,
  output logic                      afu_rst_n,
  output logic                      start_fetch,
  output logic                      start_err
);

  import afu_pkg::*;

  job_state_e state;
  logic [1:0] rst_hold;
  logic       rst_req;
  logic       busy;

  assign rst_req     = soft_reset || job_in.reset;
  assign busy        = (state == FETCH) || (state == RUN);
  assign start_fetch = (state == FETCH);
  assign start_err   = job_in.start && busy;

  // Reset sources stretched to two cycles, then merged with rst_n
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rst_hold <= 2'b00;
    end else if (rst_req) begin
      rst_hold <= 2'b11;
    end else begin
      rst_hold <= {rst_hold[0], 1'b0};
    end
  end

  assign afu_rst_n = rst_n && !rst_hold[1];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      job_out <= '0;
    end else if (rst_req) begin
      state   <= IDLE;
      job_out <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (job_in.start) begin
            state   <= FETCH;
            job_out <= '{running: 1'b1, done: 1'b0, failed: 1'b0};
          end
        end
        FETCH, RUN: begin
          // Errors win over a finish in the same cycle
          if (|report_errors) begin
            state   <= DONE;
            job_out <= '{running: 1'b0, done: 1'b1, failed: 1'b1};
          end else if (finish) begin
            state   <= DONE;
            job_out <= '{running: 1'b0, done: 1'b1, failed: 1'b0};
          end else if (state == FETCH) begin
            state <= RUN;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: common/afu_pkg.sv
package afu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W      = 64;
  localparam int ERR_W       = 4;
  // Address field in the shared structs, upper bound for ADDR_W
  localparam int HOST_ADDR_W = 32;
  localparam int COUNT_W     = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    REG_STATUS   = 2'd0,
    REG_PROGRESS = 2'd1,
    REG_ERRORS   = 2'd2,
    REG_CONTROL  = 2'd3
  } mmio_reg_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FETCH = 2'd1,
    RUN   = 2'd2,
    DONE  = 2'd3
  } job_state_e;

  // Bit positions in the error vector
  typedef enum logic [1:0] {
    ERR_MMIO_ADDR = 2'd0,
    ERR_MEM_RSP   = 2'd1,
    ERR_JOB_START = 2'd2,
    ERR_WED_COUNT = 2'd3
  } err_bit_e;

  ////////////////////////////////////////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                   start;
    logic                   reset;
    logic [HOST_ADDR_W-1:0] wed_addr;
  } job_in_t;

  typedef struct packed {
    logic running;
    logic done;
    logic failed;
  } job_out_t;

  typedef struct packed {
    logic              req;
    logic              write;
    mmio_reg_e         addr;
    logic [DATA_W-1:0] wdata;
  } mmio_in_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } mmio_out_t;

  typedef struct packed {
    logic                   req;
    mem_op_e                op;
    logic [HOST_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      wdata;
  } mem_cmd_t;

  typedef struct packed {
    logic              ack;
    logic              ok;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // Decoded work element descriptor
  typedef struct packed {
    logic [HOST_ADDR_W-1:0] src_addr;
    logic [HOST_ADDR_W-1:0] dst_addr;
    logic [COUNT_W-1:0]     count;
    logic [DATA_W-1:0]      addend;
  } wed_t;

endpackage
